//--- design/cache_cfg.svh
`default_nettype none

`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// geometry of the two-way cache
`define CACHE_ADDR_W 64
`define CACHE_WORD_W 32 // only 32 is supported
`define CACHE_LINE_BYTES 64
`define CACHE_OFFSET_W 6 // log2 of line bytes
`define CACHE_INDEX_W 9 // 512 sets

`endif

`default_nettype wire

//--- design/cachePkg.sv
`include "cache_cfg.svh"
`default_nettype none

package cachePkg;

	typedef logic [`CACHE_ADDR_W-1:0] addrT;
	typedef logic [`CACHE_WORD_W-1:0] wordT;
	typedef logic [`CACHE_LINE_BYTES*8-1:0] lineT; // word 0 in the low bits
	typedef logic [`CACHE_ADDR_W-`CACHE_INDEX_W-`CACHE_OFFSET_W-1:0] tagT;
	typedef logic [`CACHE_INDEX_W-1:0] indexT;
	typedef logic [$clog2(`CACHE_LINE_BYTES/(`CACHE_WORD_W/8))-1:0] wordSelT;

	typedef enum logic {
		OP_READ,
		OP_WRITE
	} cacheOp;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOOKUP,
		ST_WRITEBACK, // storeEnable is high here
		ST_WAITSTORE,
		ST_FETCH, // fetchEnable is high here
		ST_WAITFILL
	} cacheState;

endpackage

`default_nettype wire

//--- design/cacheRequestReg.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"
`default_nettype none

module cacheRequestReg (
	input wire logic clk,
	input wire logic reset,
	input wire logic load,
	input wire cachePkg::cacheOp reqOp,
	input wire cachePkg::addrT reqAddr,
	input wire cachePkg::wordT reqWriteData,
	output cachePkg::cacheOp op,
	output cachePkg::tagT tag,
	output cachePkg::indexT index,
	output cachePkg::wordSelT wordSel,
	output cachePkg::wordT writeWord,
	output cachePkg::addrT lineAddr
);

	cachePkg::addrT addrQ;

	always_ff @(posedge clk) begin
		if (reset) begin
			op <= cachePkg::OP_READ;
			addrQ <= '0; // keeps index known before the first request
		end else if (load) begin
			op <= reqOp;
			addrQ <= reqAddr;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			writeWord <= reqWriteData;
		end
	end

	// held through the whole miss so the replay sees the same address
	assign tag = addrQ[`CACHE_ADDR_W-1:`CACHE_OFFSET_W+`CACHE_INDEX_W];
	assign index = addrQ[`CACHE_OFFSET_W+`CACHE_INDEX_W-1:`CACHE_OFFSET_W];
	assign wordSel = addrQ[`CACHE_OFFSET_W-1:`CACHE_OFFSET_W-$bits(cachePkg::wordSelT)];
	assign lineAddr = {addrQ[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

//--- design/cacheTagStore.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"
`default_nettype none

module cacheTagStore (
	input wire logic clk,
	input wire logic reset,
	input wire cachePkg::tagT tag,
	input wire cachePkg::indexT index,
	input wire logic markWrite,
	input wire logic touch,
	input wire logic install,
	input wire logic way,
	output logic hit,
	output logic hitWay,
	output logic victimWay,
	output logic victimDirty,
	output cachePkg::tagT victimTag
);

	localparam int SETS = 1 << `CACHE_INDEX_W;

	cachePkg::tagT tagArr [2][SETS];
	logic [SETS-1:0] validBits [2];
	logic [SETS-1:0] dirtyBits [2];
	logic [SETS-1:0] lruBits; // names the least recently used way
	logic [1:0] hitVec;

	always_ff @(posedge clk) begin
		if (install) begin
			tagArr[way][index] <= tag;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			validBits[0] <= '0;
			validBits[1] <= '0;
			dirtyBits[0] <= '0;
			dirtyBits[1] <= '0;
			lruBits <= '0;
		end else begin
			if (install) begin
				validBits[way][index] <= 1'b1;
				dirtyBits[way][index] <= 1'b0; // fresh line is clean
			end
			if (markWrite) begin
				dirtyBits[way][index] <= 1'b1;
			end
			if (touch) begin
				lruBits[index] <= ~way;
			end
		end
	end

	assign hitVec[0] = validBits[0][index] && (tagArr[0][index] == tag);
	assign hitVec[1] = validBits[1][index] && (tagArr[1][index] == tag);
	assign hit = |hitVec;
	assign hitWay = hitVec[1];

	// an empty way wins over the LRU way
	always_comb begin
		if (!validBits[0][index]) begin
			victimWay = 1'b0;
		end else if (!validBits[1][index]) begin
			victimWay = 1'b1;
		end else begin
			victimWay = lruBits[index];
		end
	end

	assign victimDirty = validBits[victimWay][index] && dirtyBits[victimWay][index];
	assign victimTag = tagArr[victimWay][index];

	// a tag is only installed after a miss, so no set can hold it twice
	assert property (@(posedge clk) disable iff (reset) !(hitVec[0] && hitVec[1]));

endmodule

`default_nettype wire

//--- design/cacheDataStore.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"
`default_nettype none

module cacheDataStore (
	input wire logic clk,
	input wire cachePkg::indexT index,
	input wire cachePkg::wordSelT wordSel,
	input wire logic way,
	input wire logic writeEnable,
	input wire logic fillEnable,
	input wire cachePkg::wordT writeWord,
	input wire cachePkg::lineT fillData,
	output cachePkg::wordT readWord,
	output cachePkg::lineT victimLine
);

	localparam int SETS = 1 << `CACHE_INDEX_W;
	localparam int WORD_W = $bits(cachePkg::wordT);

	cachePkg::lineT lines [2][SETS];

	always_ff @(posedge clk) begin
		if (fillEnable) begin
			lines[way][index] <= fillData; // whole line from memory
		end else if (writeEnable) begin
			lines[way][index][wordSel*WORD_W +: WORD_W] <= writeWord;
		end
	end

	assign readWord = lines[way][index][wordSel*WORD_W +: WORD_W];
	assign victimLine = lines[way][index];

endmodule

`default_nettype wire

//--- design/cacheController.sv
`timescale 1ns/1ps
`default_nettype none

module cacheController (
	input wire logic clk,
	input wire logic reset,
	input wire logic reqValid,
	input wire cachePkg::cacheOp op,
	input wire logic hit,
	input wire logic hitWay,
	input wire logic victimWay,
	input wire logic victimDirty,
	input wire logic storeReady,
	input wire logic fetchReady,
	output logic ready,
	output logic load,
	output logic wordWrite,
	output logic markWrite,
	output logic touch,
	output logic install,
	output logic fillEnable,
	output logic startStore,
	output logic startFetch,
	output logic finish,
	output logic way
);

	cachePkg::cacheState state;
	cachePkg::cacheState stateNext;
	logic victimQ;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cachePkg::ST_IDLE;
			victimQ <= 1'b0;
		end else begin
			state <= stateNext;
			if (state == cachePkg::ST_LOOKUP) begin
				victimQ <= victimWay; // tag arrays stay put until the fill
			end
		end
	end

	always_comb begin
		stateNext = state;
		load = 1'b0;
		wordWrite = 1'b0;
		markWrite = 1'b0;
		touch = 1'b0;
		install = 1'b0;
		fillEnable = 1'b0;
		startStore = 1'b0;
		startFetch = 1'b0;
		finish = 1'b0;
		case (state)
			cachePkg::ST_IDLE: begin
				if (reqValid) begin
					load = 1'b1;
					stateNext = cachePkg::ST_LOOKUP;
				end
			end
			cachePkg::ST_LOOKUP: begin
				if (hit) begin
					touch = 1'b1;
					finish = 1'b1;
					if (op == cachePkg::OP_WRITE) begin
						wordWrite = 1'b1;
						markWrite = 1'b1;
					end
					stateNext = cachePkg::ST_IDLE;
				end else if (victimDirty) begin
					startStore = 1'b1; // flush first
					stateNext = cachePkg::ST_WRITEBACK;
				end else begin
					startFetch = 1'b1;
					stateNext = cachePkg::ST_FETCH;
				end
			end
			cachePkg::ST_WRITEBACK: stateNext = cachePkg::ST_WAITSTORE;
			cachePkg::ST_WAITSTORE: begin
				if (storeReady) begin
					startFetch = 1'b1;
					stateNext = cachePkg::ST_FETCH;
				end
			end
			cachePkg::ST_FETCH: stateNext = cachePkg::ST_WAITFILL;
			cachePkg::ST_WAITFILL: begin
				if (fetchReady) begin
					fillEnable = 1'b1;
					install = 1'b1;
					stateNext = cachePkg::ST_LOOKUP; // replay, hits now
				end
			end
			default: stateNext = cachePkg::ST_IDLE;
		endcase
	end

	assign ready = (state == cachePkg::ST_IDLE);
	assign way = (state == cachePkg::ST_LOOKUP) ? (hit ? hitWay : victimWay) : victimQ;

	assert property (@(posedge clk) disable iff (reset) !(startStore && startFetch));
	assert property (@(posedge clk) disable iff (reset)
		finish |-> (state == cachePkg::ST_LOOKUP && hit));

endmodule

`default_nettype wire

//--- design/cacheBusUnit.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"
`default_nettype none

module cacheBusUnit (
	input wire logic clk,
	input wire logic reset,
	input wire logic startStore,
	input wire logic startFetch,
	input wire logic finish,
	input wire cachePkg::tagT victimTag,
	input wire cachePkg::indexT index,
	input wire cachePkg::addrT lineAddr,
	input wire cachePkg::lineT victimLine,
	input wire cachePkg::wordT readWord,
	output logic storeEnable,
	output logic fetchEnable,
	output logic respDone,
	output cachePkg::addrT storeAddr,
	output cachePkg::addrT fetchAddr,
	output cachePkg::lineT flushData,
	output cachePkg::wordT readData
);

	// one-cycle strobes
	always_ff @(posedge clk) begin
		if (reset) begin
			storeEnable <= 1'b0;
			fetchEnable <= 1'b0;
			respDone <= 1'b0;
		end else begin
			storeEnable <= startStore;
			fetchEnable <= startFetch;
			respDone <= finish;
		end
	end

	always_ff @(posedge clk) begin
		if (startStore) begin
			storeAddr <= {victimTag, index, {`CACHE_OFFSET_W{1'b0}}}; // victim line address
			flushData <= victimLine;
		end
		if (startFetch) begin
			fetchAddr <= lineAddr;
		end
		if (finish) begin
			readData <= readWord;
		end
	end

endmodule

`default_nettype wire

//--- design/setAssocCache.sv
`timescale 1ns/1ps
`default_nettype none

module setAssocCache (
	input wire logic clk,
	input wire logic reset,
	input wire logic reqValid,
	input wire cachePkg::cacheOp reqOp,
	input wire cachePkg::addrT reqAddr,
	input wire cachePkg::wordT reqWriteData,
	output logic ready,
	output logic respDone,
	output cachePkg::wordT readData,
	output logic storeEnable,
	output cachePkg::addrT storeAddr,
	output cachePkg::lineT flushData,
	output logic fetchEnable,
	output cachePkg::addrT fetchAddr,
	input wire logic storeReady,
	input wire logic fetchReady,
	input wire cachePkg::lineT fillData
);

	cachePkg::cacheOp op;
	cachePkg::tagT tag;
	cachePkg::indexT index;
	cachePkg::wordSelT wordSel;
	cachePkg::wordT writeWord;
	cachePkg::addrT lineAddr;
	cachePkg::tagT victimTag;
	cachePkg::wordT readWord;
	cachePkg::lineT victimLine;
	logic hit;
	logic hitWay;
	logic victimWay;
	logic victimDirty;
	logic load;
	logic wordWrite;
	logic markWrite;
	logic touch;
	logic install;
	logic fillEnable;
	logic startStore;
	logic startFetch;
	logic finish;
	logic way;

	cacheRequestReg u_requestReg (
		.clk(clk), .reset(reset), .load(load),
		.reqOp(reqOp), .reqAddr(reqAddr), .reqWriteData(reqWriteData),
		.op(op), .tag(tag), .index(index), .wordSel(wordSel),
		.writeWord(writeWord), .lineAddr(lineAddr)
	);

	cacheTagStore u_tagStore (
		.clk(clk), .reset(reset), .tag(tag), .index(index),
		.markWrite(markWrite), .touch(touch), .install(install), .way(way),
		.hit(hit), .hitWay(hitWay), .victimWay(victimWay),
		.victimDirty(victimDirty), .victimTag(victimTag)
	);

	cacheDataStore u_dataStore (
		.clk(clk), .index(index), .wordSel(wordSel), .way(way),
		.writeEnable(wordWrite), .fillEnable(fillEnable),
		.writeWord(writeWord), .fillData(fillData),
		.readWord(readWord), .victimLine(victimLine)
	);

	cacheController u_controller (
		.clk(clk), .reset(reset), .reqValid(reqValid), .op(op),
		.hit(hit), .hitWay(hitWay), .victimWay(victimWay), .victimDirty(victimDirty),
		.storeReady(storeReady), .fetchReady(fetchReady),
		.ready(ready), .load(load), .wordWrite(wordWrite), .markWrite(markWrite),
		.touch(touch), .install(install), .fillEnable(fillEnable),
		.startStore(startStore), .startFetch(startFetch), .finish(finish), .way(way)
	);

	cacheBusUnit u_busUnit (
		.clk(clk), .reset(reset),
		.startStore(startStore), .startFetch(startFetch), .finish(finish),
		.victimTag(victimTag), .index(index), .lineAddr(lineAddr),
		.victimLine(victimLine), .readWord(readWord),
		.storeEnable(storeEnable), .fetchEnable(fetchEnable), .respDone(respDone),
		.storeAddr(storeAddr), .fetchAddr(fetchAddr),
		.flushData(flushData), .readData(readData)
	);

endmodule

`default_nettype wire

//--- tests/cacheMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module cacheMemModel (
	input wire logic clk,
	input wire logic reset,
	input wire logic storeEnable,
	input wire cachePkg::addrT storeAddr,
	input wire cachePkg::lineT flushData,
	input wire logic fetchEnable,
	input wire cachePkg::addrT fetchAddr,
	output logic storeReady,
	output logic fetchReady,
	output cachePkg::lineT fillData,
	output int storeCount,
	output int fetchCount,
	output cachePkg::addrT lastStoreAddr,
	output cachePkg::lineT lastStoreData
);

	localparam int WORDS = 16;

	cachePkg::lineT mem [cachePkg::addrT];
	cachePkg::addrT pendAddr;
	integer seed;
	int storeWait;
	int fetchWait;

	initial begin
		seed = 54;
		storeReady = 1'b0;
		fetchReady = 1'b0;
		fillData = '0;
	end

	// untouched lines follow the address pattern
	function automatic cachePkg::lineT lineOf(input cachePkg::addrT a);
		cachePkg::lineT l;
		if (mem.exists(a)) begin
			return mem[a];
		end
		for (int w = 0; w < WORDS; w++) begin
			l[w*32 +: 32] = a[31:0] ^ (32'(w) * 32'h01010101);
		end
		return l;
	endfunction

	always @(posedge clk) begin
		storeReady <= 1'b0;
		fetchReady <= 1'b0;
		if (reset) begin
			storeCount <= 0;
			fetchCount <= 0;
			storeWait = 0;
			fetchWait = 0;
		end else begin
			if (storeEnable) begin
				mem[storeAddr] = flushData;
				storeCount <= storeCount + 1;
				lastStoreAddr <= storeAddr;
				lastStoreData <= flushData;
				storeWait = 1 + ($unsigned($random(seed)) % 4); // 1 to 4 cycles
			end else if (storeWait > 0) begin
				storeWait = storeWait - 1;
				if (storeWait == 0) begin
					storeReady <= 1'b1;
				end
			end
			if (fetchEnable) begin
				pendAddr = fetchAddr;
				fetchCount <= fetchCount + 1;
				fetchWait = 1 + ($unsigned($random(seed)) % 4);
			end else if (fetchWait > 0) begin
				fetchWait = fetchWait - 1;
				if (fetchWait == 0) begin
					fillData <= lineOf(pendAddr);
					fetchReady <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/setAssocCacheTb.sv
`timescale 1ns/1ps
`include "cache_cfg.svh"
`default_nettype none

module setAssocCacheTb;

	localparam int N_DIR = 11;
	localparam int N_RAND = 16;
	localparam int N = N_DIR + N_RAND;
	localparam int MISS_CYCLES = 24; // flush, fetch and replay at the longest delays
	localparam int CYCLE_LIMIT = N * MISS_CYCLES + 40;

	logic clk;
	logic reset;
	logic reqValid;
	cachePkg::cacheOp reqOp;
	cachePkg::addrT reqAddr;
	cachePkg::wordT reqWriteData;
	logic ready;
	logic respDone;
	cachePkg::wordT readData;
	logic storeEnable;
	cachePkg::addrT storeAddr;
	cachePkg::lineT flushData;
	logic fetchEnable;
	cachePkg::addrT fetchAddr;
	logic storeReady;
	logic fetchReady;
	cachePkg::lineT fillData;
	int storeCount;
	int fetchCount;
	cachePkg::addrT lastStoreAddr;
	cachePkg::lineT lastStoreData;

	cachePkg::cacheOp tOp [N];
	cachePkg::addrT tAddr [N];
	cachePkg::wordT tData [N];
	int tStores [N]; // -1 skips the count checks
	int tFetches [N];
	cachePkg::addrT tStoreAddr [N];
	cachePkg::wordT shadow [cachePkg::addrT];
	integer seed;
	int errors;
	int cycles;

	setAssocCache u_dut (
		.clk(clk), .reset(reset), .reqValid(reqValid), .reqOp(reqOp),
		.reqAddr(reqAddr), .reqWriteData(reqWriteData),
		.ready(ready), .respDone(respDone), .readData(readData),
		.storeEnable(storeEnable), .storeAddr(storeAddr), .flushData(flushData),
		.fetchEnable(fetchEnable), .fetchAddr(fetchAddr),
		.storeReady(storeReady), .fetchReady(fetchReady), .fillData(fillData)
	);

	cacheMemModel u_mem (
		.clk(clk), .reset(reset), .storeEnable(storeEnable), .storeAddr(storeAddr),
		.flushData(flushData), .fetchEnable(fetchEnable), .fetchAddr(fetchAddr),
		.storeReady(storeReady), .fetchReady(fetchReady), .fillData(fillData),
		.storeCount(storeCount), .fetchCount(fetchCount),
		.lastStoreAddr(lastStoreAddr), .lastStoreData(lastStoreData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: cache stopped answering after %0d cycles", cycles);
			$display("errors: %0d", errors);
			$display("Simulation FAILED");
			$finish;
		end
	end

	function automatic cachePkg::addrT makeAddr(input int tag, input int set, input int word);
		return (64'(tag) << (`CACHE_OFFSET_W + `CACHE_INDEX_W)) | (64'(set) << `CACHE_OFFSET_W)
			| (64'(word) << 2);
	endfunction

	// written words, else the memory pattern of the line
	function automatic cachePkg::wordT expectedWord(input cachePkg::addrT a);
		cachePkg::wordT w;
		if (shadow.exists(a)) begin
			w = shadow[a];
		end else begin
			w = {a[31:6], 6'b0} ^ (32'(a[5:2]) * 32'h01010101);
		end
		return w;
	endfunction

	task automatic compareValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic setEntry(input int i, input cachePkg::cacheOp op, input int tag, input int set,
		input int word, input cachePkg::wordT data, input int st, input int fe, input int stTag);
		tOp[i] = op;
		tAddr[i] = makeAddr(tag, set, word);
		tData[i] = data;
		tStores[i] = st;
		tFetches[i] = fe;
		tStoreAddr[i] = (stTag != 0) ? makeAddr(stTag, set, 0) : '0;
	endtask

	task automatic buildTable();
		setEntry(0, cachePkg::OP_READ, 1, 3, 2, '0, 0, 1, 0); // cold read
		setEntry(1, cachePkg::OP_WRITE, 1, 3, 2, 32'hA5A50001, 0, 0, 0);
		setEntry(2, cachePkg::OP_READ, 1, 3, 2, '0, 0, 0, 0);
		setEntry(3, cachePkg::OP_READ, 2, 3, 5, '0, 0, 1, 0); // second way
		setEntry(4, cachePkg::OP_READ, 1, 3, 2, '0, 0, 0, 0);
		setEntry(5, cachePkg::OP_WRITE, 3, 3, 0, 32'hDEAD0003, 0, 1, 0); // clean victim
		setEntry(6, cachePkg::OP_READ, 2, 3, 5, '0, 1, 1, 1); // dirty victim
		setEntry(7, cachePkg::OP_READ, 1, 3, 2, '0, 1, 1, 3);
		setEntry(8, cachePkg::OP_READ, 3, 3, 0, '0, 0, 1, 0);
		setEntry(9, cachePkg::OP_WRITE, 2, 7, 1, 32'h12340009, 0, 1, 0);
		setEntry(10, cachePkg::OP_READ, 2, 7, 1, '0, 0, 0, 0);
		for (int i = N_DIR; i < N; i++) begin
			setEntry(i, cachePkg::cacheOp'($random(seed) & 1), 1 + ($unsigned($random(seed)) % 3),
				($random(seed) & 1) ? 7 : 3, $unsigned($random(seed)) % 16, $random(seed), -1, -1, 0);
		end
	endtask

	task automatic runEntry(input int i);
		int s0;
		int f0;
		int n;
		cachePkg::addrT lineA;
		lineA = {tAddr[i][63:6], 6'b0};
		@(negedge clk);
		while (!ready) begin
			@(negedge clk);
		end
		s0 = storeCount;
		f0 = fetchCount;
		@(posedge clk);
		reqValid <= 1'b1;
		reqOp <= tOp[i];
		reqAddr <= tAddr[i];
		reqWriteData <= tData[i];
		@(posedge clk); // request sampled here
		reqValid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!respDone);
		if (tOp[i] == cachePkg::OP_WRITE) begin
			shadow[tAddr[i]] = tData[i];
		end else begin
			compareValue("readData", readData, expectedWord(tAddr[i]));
		end
		if (tStores[i] >= 0) begin
			compareValue("store count", storeCount - s0, tStores[i]);
			compareValue("fetch count", fetchCount - f0, tFetches[i]);
		end
		if (fetchCount != f0) begin
			compareValue("fetchAddr", fetchAddr, lineA);
		end else begin
			compareValue("hit latency", n, 2);
		end
		if (storeCount != s0) begin
			if (tStoreAddr[i] != '0) begin
				compareValue("storeAddr", lastStoreAddr, tStoreAddr[i]);
			end
			for (int w = 0; w < 16; w++) begin
				compareValue("flushData", lastStoreData[w*32 +: 32],
					expectedWord(lastStoreAddr + 64'(4 * w)));
			end
		end
	endtask

	initial begin
		seed = 54;
		errors = 0;
		cycles = 0;
		reset = 1'b1;
		reqValid = 1'b0;
		reqOp = cachePkg::OP_READ;
		reqAddr = '0;
		reqWriteData = '0;
		buildTable();
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		repeat (3) begin
			@(negedge clk);
			compareValue("ready", ready, 1'b1);
			compareValue("storeEnable", storeEnable, 1'b0);
			compareValue("fetchEnable", fetchEnable, 1'b0);
			compareValue("respDone", respDone, 1'b0);
		end
		for (int i = 0; i < N; i++) begin
			runEntry(i);
		end
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- setAssocCache.f
+incdir+design
design/cachePkg.sv
design/cacheRequestReg.sv
design/cacheTagStore.sv
design/cacheDataStore.sv
design/cacheController.sv
design/cacheBusUnit.sv
design/setAssocCache.sv
tests/cacheMemModel.sv
tests/setAssocCacheTb.sv

//--- Bender.yml
package:
  name: setAssocCache

sources:
  - include_dirs:
      - design
    files:
      - design/cachePkg.sv
      - design/cacheRequestReg.sv
      - design/cacheTagStore.sv
      - design/cacheDataStore.sv
      - design/cacheController.sv
      - design/cacheBusUnit.sv
      - design/setAssocCache.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/cacheMemModel.sv
      - tests/setAssocCacheTb.sv
